// File: Makefile
# Verilator build and run for the scope self-test data path

VERILATOR ?= verilator
TOP       ?= scope_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@rm -f $(LOG)
	./$(BINARY) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/clock_gen.sv
// Testbench clock source and active low power-on reset
`timescale 1ns/100ps

module clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clock,
    output logic reset
);

    logic reset_level = 1'b0;

    assign reset = reset_level;

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // Reset is released on a rising edge once the count is reached
    initial begin
        repeat (RESET_CYCLES) @(posedge clock);
        reset_level <= 1'b1;
    end

endmodule

// File: bench/scope_tb.sv
// Testbench for the scope data path with output model, assertions and watchdog
`timescale 1ns/100ps

module scope_tb;
    import scope_pkg::*;

    localparam int N_CHANNELS    = 3;
    localparam int DEST_START    = 1;
    localparam int MAX_PACKET    = 16;
    localparam int BACKOFF_DELAY = 32;
    localparam int RANDOM_SEED   = 92;
    localparam int ENABLE_FRAMES = 5;
    localparam int QUIET_CYCLES  = 100;
    // Watchdog budget in clock cycles
    localparam int MAX_FRAMES       = 20;
    localparam int CYCLES_PER_FRAME = 400;

    logic        clock;
    logic        reset;
    logic        enable = 1'b0;
    logic        trigger = 1'b0;
    logic [15:0] packet_length = 16'd1;
    sample_t     out_data;
    dest_t       out_dest;
    logic        out_valid;
    logic        out_last;
    logic        busy;

    // Model of the expected output order
    int      exp_index = 0;
    int      exp_dest = DEST_START;
    int      word_count = 0;
    int      frames_done = 0;
    int      after_last = 0;
    int      frame_words;
    sample_t expected_data;
    logic    prev_reset_low = 1'b0;
    logic    quiet_window = 1'b0;

    clock_gen #(.PERIOD(10), .RESET_CYCLES(3)) clocks (.clock(clock), .reset(reset));

    scope_top #(
        .N_CHANNELS    (N_CHANNELS),
        .DEST_START    (DEST_START),
        .MAX_PACKET    (MAX_PACKET),
        .BACKOFF_DELAY (BACKOFF_DELAY)
    ) UUT (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .trigger       (trigger),
        .packet_length (packet_length),
        .out_data      (out_data),
        .out_dest      (out_dest),
        .out_valid     (out_valid),
        .out_last      (out_last),
        .busy          (busy)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic report_mismatch(input string test_name, input int expected, input int actual);
        stop_with_failure($sformatf("CHECK FAILED %s: expected %0d, actual %0d",
                                    test_name, expected, actual));
    endtask

    function automatic logic [15:0] random_length();
        return 16'($urandom_range(MAX_PACKET, 1));
    endfunction

    // Outputs are looked at on the falling edge, away from the register updates
    task automatic wait_frame_end();
        do @(negedge clock); while (!out_last);
    endtask

    task automatic wait_idle();
        do @(negedge clock); while (busy);
    endtask

    assign frame_words   = N_CHANNELS * int'(packet_length);
    assign expected_data = sample_t'(exp_index + DEST_WEIGHT * exp_dest);

    // Index runs 0 to packet_length - 1 within each destination, destinations ascend
    always @(posedge clock) begin
        prev_reset_low <= !reset;
        if (!reset) begin
            exp_index  <= 0;
            exp_dest   <= DEST_START;
            word_count <= 0;
        end else if (out_valid && out_last) begin
            exp_index   <= 0;
            exp_dest    <= DEST_START;
            word_count  <= 0;
            frames_done <= frames_done + 1;
        end else if (out_valid) begin
            word_count <= word_count + 1;
            if (exp_index == int'(packet_length) - 1) begin
                exp_index <= 0;
                exp_dest  <= exp_dest + 1;
            end else begin
                exp_index <= exp_index + 1;
            end
        end
    end

    // Cycles since the final word of a frame, used for the backoff checks
    always @(posedge clock) begin
        if (!reset) begin
            after_last <= 0;
        end else if (out_last) begin
            after_last <= 1;
        end else if (after_last == BACKOFF_DELAY + 2) begin
            after_last <= 0;
        end else if (after_last != 0) begin
            after_last <= after_last + 1;
        end
    end

    reset_quiet: assert property (@(posedge clock)
        prev_reset_low |-> !(out_valid || out_last || busy))
        else report_mismatch("reset quiet", 0,
                             int'({$sampled(out_valid), $sampled(out_last), $sampled(busy)}));

    idle_quiet: assert property (@(posedge clock) disable iff (!reset)
        quiet_window |-> !(out_valid || busy))
        else report_mismatch("idle quiet", 0, int'({$sampled(out_valid), $sampled(busy)}));

    sample_value: assert property (@(posedge clock) disable iff (!reset)
        out_valid |-> (out_data == expected_data))
        else report_mismatch("sample value", int'($sampled(expected_data)),
                             int'($sampled(out_data)));

    sample_dest: assert property (@(posedge clock) disable iff (!reset)
        out_valid |-> (int'(out_dest) == exp_dest))
        else report_mismatch("sample destination", $sampled(exp_dest),
                             int'($sampled(out_dest)));

    frame_size: assert property (@(posedge clock) disable iff (!reset)
        out_valid |-> (word_count < frame_words))
        else report_mismatch("frame size", $sampled(frame_words), $sampled(word_count) + 1);

    last_on_final: assert property (@(posedge clock) disable iff (!reset)
        (out_valid && word_count == frame_words - 1) |-> out_last)
        else report_mismatch("last on final word", 1, int'($sampled(out_last)));

    last_only_final: assert property (@(posedge clock) disable iff (!reset)
        out_last |-> (out_valid && word_count == frame_words - 1))
        else report_mismatch("last position", $sampled(frame_words) - 1, $sampled(word_count));

    no_gaps: assert property (@(posedge clock) disable iff (!reset)
        (out_valid && !out_last) |=> out_valid)
        else report_mismatch("continuous output", 1, int'($sampled(out_valid)));

    backoff_busy: assert property (@(posedge clock) disable iff (!reset)
        (after_last >= 1 && after_last <= BACKOFF_DELAY + 1) |-> busy)
        else report_mismatch("busy during backoff", 1, int'($sampled(busy)));

    backoff_release: assert property (@(posedge clock) disable iff (!reset)
        (after_last == BACKOFF_DELAY + 2) |-> !busy)
        else report_mismatch("idle after backoff", 0, int'($sampled(busy)));

    initial begin : watchdog
        repeat (MAX_FRAMES * CYCLES_PER_FRAME) @(posedge clock);
        stop_with_failure("Timeout: the tests did not finish within the cycle budget");
    end

    initial begin : stimulus
        void'($urandom(RANDOM_SEED));
        do @(negedge clock); while (!reset);

        // Nothing may move while both start inputs stay low
        @(posedge clock);
        quiet_window <= 1'b1;
        repeat (5) @(posedge clock);
        quiet_window <= 1'b0;

        // Single trigger edge, trigger kept high well past the frame
        packet_length <= random_length();
        trigger       <= 1'b1;
        wait_frame_end();
        wait_idle();
        @(posedge clock);
        quiet_window <= 1'b1;
        repeat (QUIET_CYCLES) @(posedge clock);
        quiet_window <= 1'b0;
        trigger      <= 1'b0;

        // A fresh rising edge starts exactly one more frame
        @(posedge clock);
        packet_length <= random_length();
        @(posedge clock);
        trigger <= 1'b1;
        wait_frame_end();
        @(posedge clock);
        trigger <= 1'b0;
        wait_idle();

        // Level enable repeats frames, the length changes while the generator waits
        @(posedge clock);
        packet_length <= random_length();
        enable        <= 1'b1;
        for (int f = 1; f <= ENABLE_FRAMES; f++) begin
            wait_frame_end();
            @(posedge clock);
            if (f == ENABLE_FRAMES) begin
                enable <= 1'b0;
            end else begin
                packet_length <= random_length();
            end
        end
        wait_idle();
        repeat (2) @(posedge clock);

        if (frames_done != ENABLE_FRAMES + 2) begin
            report_mismatch("frame count", ENABLE_FRAMES + 2, frames_done);
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// File: build.f
common/scope_pkg.sv
common/sample_stream_if.sv
common/readout_if.sv
hw/data_gen/scope_data_gen.sv
hw/channel_capture.sv
hw/collector/frame_collector.sv
hw/scope_top.sv
bench/clock_gen.sv
bench/scope_tb.sv

// File: common/readout_if.sv
// Read port interface between one channel buffer and the frame collector
`timescale 1ns/100ps

interface readout_if;
    import scope_pkg::*;

    logic [15:0] rd_addr;
    logic        rd_en;
    // Valid one cycle after rd_en
    sample_t     rd_data;
    // Number of words held in the buffer
    logic [15:0] count;
    logic        clear;

    modport buffer (
        input  rd_addr,
        input  rd_en,
        input  clear,
        output rd_data,
        output count
    );

    modport reader (
        output rd_addr,
        output rd_en,
        output clear,
        input  rd_data,
        input  count
    );

endinterface

// File: common/sample_stream_if.sv
// Sample stream interface from the pattern generator to the channel buffers
`timescale 1ns/100ps

interface sample_stream_if;
    import scope_pkg::*;

    sample_t data;
    dest_t   dest;
    logic    valid;
    // High together with the final word of the final destination
    logic    last;

    modport source (
        output data,
        output dest,
        output valid,
        output last
    );

    modport sink (
        input data,
        input dest,
        input valid,
        input last
    );

endinterface

// File: common/scope_pkg.sv
// Sample and destination types, test pattern constants and FSM state encodings
package scope_pkg;

    // One acquired sample word
    typedef logic [31:0] sample_t;

    // Destination (channel) number carried with each sample
    typedef logic [7:0] dest_t;

    // Offset added per destination number in the self-test pattern
    localparam int DEST_WEIGHT = 2000;

    // Idle cycles between two samples of the same packet
    localparam int SAMPLE_SPACING = 6;

    typedef enum logic [2:0] {
        gen_idle      = 3'd0,
        gen_advance   = 3'd1,
        gen_spacing   = 3'd2,
        gen_wait_done = 3'd3,
        gen_backoff   = 3'd4
    } gen_state_e;

    typedef enum logic [1:0] {
        col_wait_frame   = 2'd0,
        col_read_channel = 2'd1,
        col_finish       = 2'd2,
        col_release      = 2'd3
    } collect_state_e;

endpackage

// File: hw/channel_capture.sv
// Single channel sample buffer with write counter, registered read and clear
`timescale 1ns/100ps

module channel_capture #(
    parameter int CHANNEL_DEST = 1,
    parameter int MAX_PACKET   = 16
) (
    input  logic          clock,
    input  logic          reset,
    sample_stream_if.sink stream,
    readout_if.buffer     readout
);
    import scope_pkg::*;

    localparam int ADDR_W = (MAX_PACKET > 1) ? $clog2(MAX_PACKET) : 1;

    sample_t     mem [MAX_PACKET];
    logic [15:0] count;
    logic        hit;
    logic        store;

    assign hit   = stream.valid && (stream.dest == dest_t'(CHANNEL_DEST));
    // Words beyond the buffer depth are dropped
    assign store = hit && (count != 16'(MAX_PACKET));

    assign readout.count = count;

    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
        end else if (readout.clear) begin
            count <= '0;
        end else if (store) begin
            count <= count + 16'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (store) begin
            mem[count[ADDR_W-1:0]] <= stream.data;
        end
    end

    always_ff @(posedge clock) begin
        if (readout.rd_en) begin
            readout.rd_data <= mem[readout.rd_addr[ADDR_W-1:0]];
        end
    end

    // packet_length must not exceed the depth given at the top level
    no_overflow: assert property (
        @(posedge clock) disable iff (!reset) hit |-> (count != 16'(MAX_PACKET))
    );

endmodule

// File: hw/collector/frame_collector.sv
// Frame collector FSM that drains the channel buffers in order and signals dma_done
`timescale 1ns/100ps

module frame_collector #(
    parameter int N_CHANNELS = 6,
    parameter int DEST_START = 1
) (
    input  logic               clock,
    input  logic               reset,
    sample_stream_if.sink      stream,
    readout_if.reader          readout [N_CHANNELS],
    output scope_pkg::sample_t out_data,
    output scope_pkg::dest_t   out_dest,
    output logic               out_valid,
    output logic               out_last,
    output logic               dma_done
);
    import scope_pkg::*;

    localparam int CH_W = (N_CHANNELS > 1) ? $clog2(N_CHANNELS) : 1;

    collect_state_e  state;
    logic [CH_W-1:0] ch_index;
    logic [15:0]     rd_addr;
    logic [CH_W-1:0] out_ch;
    logic [15:0]     counts [N_CHANNELS];
    sample_t         rd_data [N_CHANNELS];
    logic [CH_W-1:0] sel_ch;
    logic            sel_found;
    logic            more_after;
    logic            issue;
    logic            word_done;

    // Flatten the interface array so it can be indexed by the channel counter
    for (genvar g = 0; g < N_CHANNELS; g++) begin : g_port
        assign counts[g]          = readout[g].count;
        assign rd_data[g]         = readout[g].rd_data;
        assign readout[g].rd_addr = rd_addr;
        assign readout[g].rd_en   = issue && (sel_ch == CH_W'(g));
        assign readout[g].clear   = dma_done;
    end

    // Pick the first non-empty channel at or above ch_index, and note whether
    // another non-empty one follows it, so empty channels cost no cycles
    always_comb begin
        sel_found  = 1'b0;
        sel_ch     = ch_index;
        more_after = 1'b0;
        for (int j = 0; j < N_CHANNELS; j++) begin
            if ((j >= int'(ch_index)) && (counts[j] != 16'd0)) begin
                if (sel_found) begin
                    more_after = 1'b1;
                end else begin
                    sel_found = 1'b1;
                    sel_ch    = CH_W'(j);
                end
            end
        end
    end

    assign issue     = (state == col_read_channel) && sel_found;
    assign word_done = (rd_addr == counts[sel_ch] - 16'd1);
    assign dma_done  = (state == col_release);

    always_ff @(posedge clock) begin
        if (!reset) begin
            state     <= col_wait_frame;
            ch_index  <= '0;
            rd_addr   <= '0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            // Output flags line up with the registered read data
            out_valid <= issue;
            out_last  <= issue && word_done && !more_after;
            case (state)
                col_wait_frame: begin
                    ch_index <= '0;
                    rd_addr  <= '0;
                    if (stream.valid && stream.last) begin
                        state <= col_read_channel;
                    end
                end
                col_read_channel: begin
                    if (!sel_found) begin
                        state <= col_finish;
                    end else if (word_done) begin
                        rd_addr <= '0;
                        if (more_after) begin
                            ch_index <= sel_ch + 1'b1;
                        end else begin
                            state <= col_finish;
                        end
                    end else begin
                        rd_addr  <= rd_addr + 16'd1;
                        ch_index <= sel_ch;
                    end
                end
                // Final word is on the output during this state
                col_finish: begin
                    state <= col_release;
                end
                col_release: begin
                    state <= col_wait_frame;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            out_ch <= sel_ch;
        end
    end

    assign out_data = rd_data[out_ch];
    assign out_dest = dest_t'(DEST_START) + dest_t'(out_ch);

    // The generator leaves wait_done on the first dma_done cycle
    dma_done_pulse: assert property (
        @(posedge clock) disable iff (!reset) dma_done |=> !dma_done
    );

endmodule

// File: hw/data_gen/scope_data_gen.sv
// Test pattern sequencer with trigger edge detection, sample spacing and backoff
`timescale 1ns/100ps

module scope_data_gen #(
    parameter int DEST_START    = 1,
    parameter int N_CHANNELS    = 6,
    parameter int BACKOFF_DELAY = 32
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            enable,
    input  logic            trigger,
    input  logic            dma_done,
    input  logic [15:0]     packet_length,
    output logic            busy,
    sample_stream_if.source stream
);
    import scope_pkg::*;

    localparam dest_t       FIRST_DEST  = dest_t'(DEST_START);
    localparam dest_t       LAST_DEST   = dest_t'(DEST_START + N_CHANNELS - 1);
    localparam logic [7:0]  SPACING_END = 8'(SAMPLE_SPACING - 1);
    localparam logic [15:0] BACKOFF_END = 16'(BACKOFF_DELAY - 1);

    gen_state_e  state;
    logic [15:0] sample_index;
    dest_t       dest_count;
    logic [7:0]  spacing_count;
    logic [15:0] backoff_count;
    logic        trigger_q;
    logic        start;

    // A frame starts on a level enable or on a rising trigger edge
    assign start = enable || (trigger && !trigger_q);
    assign busy  = (state != gen_idle);

    always_ff @(posedge clock) begin
        if (!reset) begin
            state         <= gen_idle;
            sample_index  <= '0;
            dest_count    <= FIRST_DEST;
            spacing_count <= '0;
            backoff_count <= '0;
            trigger_q     <= 1'b0;
            stream.valid  <= 1'b0;
            stream.last   <= 1'b0;
        end else begin
            trigger_q    <= trigger;
            stream.valid <= 1'b0;
            stream.last  <= 1'b0;
            case (state)
                gen_idle: begin
                    sample_index <= '0;
                    dest_count   <= FIRST_DEST;
                    if (start) begin
                        state <= gen_advance;
                    end
                end
                gen_advance: begin
                    stream.data   <= sample_t'(sample_index)
                                     + sample_t'(DEST_WEIGHT) * sample_t'(dest_count);
                    stream.dest   <= dest_count;
                    stream.valid  <= 1'b1;
                    spacing_count <= '0;
                    if (sample_index == packet_length - 16'd1) begin
                        sample_index <= '0;
                        if (dest_count == LAST_DEST) begin
                            stream.last <= 1'b1;
                            state       <= gen_wait_done;
                        end else begin
                            // Next destination follows without spacing
                            dest_count <= dest_count + dest_t'(1);
                        end
                    end else begin
                        sample_index <= sample_index + 16'd1;
                        state        <= gen_spacing;
                    end
                end
                gen_spacing: begin
                    if (spacing_count == SPACING_END) begin
                        state <= gen_advance;
                    end else begin
                        spacing_count <= spacing_count + 8'd1;
                    end
                end
                gen_wait_done: begin
                    backoff_count <= '0;
                    if (dma_done) begin
                        state <= gen_backoff;
                    end
                end
                gen_backoff: begin
                    if (backoff_count == BACKOFF_END) begin
                        state <= gen_idle;
                    end else begin
                        backoff_count <= backoff_count + 16'd1;
                    end
                end
                default: begin
                    state <= gen_idle;
                end
            endcase
        end
    end

    // The collector relies on last only ever riding on a valid word
    last_needs_valid: assert property (
        @(posedge clock) disable iff (!reset) stream.last |-> stream.valid
    );

endmodule

// File: hw/scope_top.sv
// Top level of the self-test data path: generator, channel buffers and collector
`timescale 1ns/100ps

module scope_top #(
    parameter int N_CHANNELS    = 6,
    parameter int DEST_START    = 1,
    parameter int MAX_PACKET    = 16,
    parameter int BACKOFF_DELAY = 32
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               enable,
    input  logic               trigger,
    input  logic [15:0]        packet_length,
    output scope_pkg::sample_t out_data,
    output scope_pkg::dest_t   out_dest,
    output logic               out_valid,
    output logic               out_last,
    output logic               busy
);

    logic dma_done;

    sample_stream_if stream ();
    readout_if       readout [N_CHANNELS] ();

    scope_data_gen #(
        .DEST_START    (DEST_START),
        .N_CHANNELS    (N_CHANNELS),
        .BACKOFF_DELAY (BACKOFF_DELAY)
    ) data_gen (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .trigger       (trigger),
        .dma_done      (dma_done),
        .packet_length (packet_length),
        .busy          (busy),
        .stream        (stream)
    );

    // One buffer per destination, numbered from DEST_START upwards
    for (genvar i = 0; i < N_CHANNELS; i++) begin : g_channel
        channel_capture #(
            .CHANNEL_DEST (DEST_START + i),
            .MAX_PACKET   (MAX_PACKET)
        ) capture (
            .clock   (clock),
            .reset   (reset),
            .stream  (stream),
            .readout (readout[i])
        );
    end

    frame_collector #(
        .N_CHANNELS (N_CHANNELS),
        .DEST_START (DEST_START)
    ) collector (
        .clock     (clock),
        .reset     (reset),
        .stream    (stream),
        .readout   (readout),
        .out_data  (out_data),
        .out_dest  (out_dest),
        .out_valid (out_valid),
        .out_last  (out_last),
        .dma_done  (dma_done)
    );

endmodule
